// File: Makefile
TOP = tb_eeprom_ctrl

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: dv/eeprom_model.sv
module eeprom_model (
    input  logic mute,
    input  logic scl,
    inout  wire  sda
);

    timeunit 1ns;
    timeprecision 1ps;

    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } mode_t;

    logic [7:0]   mem [2048];
    mode_t        mode      = M_IDLE;
    logic         scl_q     = 1'b1;
    logic         sda_q     = 1'b1;
    logic         drive_low = 1'b0;
    logic [3:0]   bit_cnt   = 4'd0;
    logic [1:0]   byte_num  = 2'd0;
    logic [7:0]   rx_byte   = 8'd0;
    logic [7:0]   tx_byte   = 8'd0;
    logic         to_tx     = 1'b0;  // read control byte seen
    eeprom_addr_u ptr       = '0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ {3'(a >> 8), 5'h16};
    end

    always @(scl or sda) begin
        if (scl_q && scl && sda_q && !sda) begin
            // start or repeated start
            mode      = M_RX;
            bit_cnt   = 4'd0;
            byte_num  = 2'd0;
            drive_low = 1'b0;
        end else if (scl_q && scl && !sda_q && sda) begin
            mode      = M_IDLE;  // stop
            drive_low = 1'b0;
        end else if (!scl_q && scl) begin
            if (mode == M_RX) begin
                rx_byte = {rx_byte[6:0], sda};
                bit_cnt = bit_cnt + 4'd1;
            end else if (mode == M_MACK) begin
                mode = M_IDLE;  // no sequential reads
            end
        end else if (scl_q && !scl) begin
            case (mode)
                M_RX: if (bit_cnt == 4'd8) begin
                    if (mute || (byte_num == 2'd0 && rx_byte[7:4] != DEV_TYPE)) begin
                        mode = M_IDLE;  // stay silent, master sees nack
                    end else begin
                        if (byte_num == 2'd0) begin
                            ptr.blk.block = rx_byte[3:1];
                            to_tx         = (rx_byte[0] == RW_READ);
                        end else if (byte_num == 2'd1) begin
                            ptr.blk.word = rx_byte;
                        end else begin
                            mem[ptr.flat] = rx_byte;
                        end
                        byte_num  = byte_num + 2'd1;
                        drive_low = 1'b1;
                        mode      = M_ACK;
                    end
                end
                M_ACK: begin
                    drive_low = 1'b0;
                    bit_cnt   = 4'd0;
                    mode      = M_RX;
                    if (to_tx) begin
                        tx_byte   = mem[ptr.flat];
                        drive_low = !tx_byte[7];  // msb right after our ack
                        bit_cnt   = 4'd1;
                        mode      = M_TX;
                    end
                end
                M_TX: begin
                    if (bit_cnt == 4'd8) begin
                        drive_low = 1'b0;
                        mode      = M_MACK;
                    end else begin
                        tx_byte   = tx_byte << 1;
                        drive_low = !tx_byte[7];
                        bit_cnt   = bit_cnt + 4'd1;
                    end
                end
                default: ;
            endcase
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// File: dv/tb_eeprom_ctrl.sv
module tb_eeprom_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    import eeprom_pkg::*;

    localparam int          SCL_QUARTER  = 4;
    localparam int          NUM_RAND     = 6;
    localparam int          NUM_STEPS    = 11 + 2 * NUM_RAND;
    localparam int          BIT_CYCLES   = 4 * SCL_QUARTER;
    localparam int          RUN_LIMIT_NS = NUM_STEPS * 40 * BIT_CYCLES * 10 + 20000;
    localparam logic [31:0] SEED         = 32'h78d7_e3fb;

    localparam logic [1:0] OP_WR   = 2'd0;
    localparam logic [1:0] OP_RD   = 2'd1;
    localparam logic [1:0] OP_BOTH = 2'd2;  // WR and RD together

    typedef struct {
        logic [1:0]  op;
        logic [10:0] addr;
        logic [7:0]  data;
        logic        mute;
        logic        poke;  // extra RD strobe while busy
        logic        exp_nack;
        logic [7:0]  exp_rdata;
    } step_t;

    logic         CLK   = 1'b0;
    logic         RESET = 1'b1;
    logic         WR    = 1'b0;
    logic         RD    = 1'b0;
    eeprom_addr_u addr  = '0;
    logic [7:0]   wdata = 8'd0;
    logic [7:0]   rdata;
    logic         ACK;
    logic         nack;
    logic         SCL;
    wire          SDA;
    logic         mute  = 1'b0;

    step_t      steps [NUM_STEPS];
    logic [7:0] shadow [2048];
    int         n_steps   = 0;
    int         ack_count = 0;

    pullup (SDA);

    eeprom_ctrl_top #(
        .SCL_QUARTER (SCL_QUARTER)
    ) UUT (
        .CLK   (CLK),
        .RESET (RESET),
        .WR    (WR),
        .RD    (RD),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .ACK   (ACK),
        .nack  (nack),
        .SCL   (SCL),
        .SDA   (SDA)
    );

    eeprom_model u_model (
        .mute (mute),
        .scl  (SCL),
        .sda  (SDA)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        if (ACK)
            ack_count <= ack_count + 1;
    end

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run($sformatf("%s does not match", name));
        end
    endtask

    task automatic add_step(input logic [1:0] op, input logic [10:0] a, input logic [7:0] d,
                            input logic m, input logic p);
        step_t s;
        s.op   = op;
        s.addr = a;
        s.data = d;
        s.mute = m;
        s.poke = p;
        s.exp_nack = m;
        if (op != OP_RD && !m)
            shadow[a] = d;  // only acknowledged writes land
        s.exp_rdata = shadow[a];
        steps[n_steps] = s;
        n_steps++;
    endtask

    task automatic build_table();
        logic [10:0] ra [NUM_RAND];
        int          order [NUM_RAND];
        int          j;
        int          t;
        add_step(OP_WR, 11'h123, 8'ha5, 1'b0, 1'b0);
        add_step(OP_RD, 11'h123, 8'h00, 1'b0, 1'b0);
        add_step(OP_WR, 11'h005, 8'h11, 1'b0, 1'b0);
        add_step(OP_WR, 11'h705, 8'h77, 1'b0, 1'b0);  // same word, other block
        add_step(OP_RD, 11'h005, 8'h00, 1'b0, 1'b0);
        add_step(OP_RD, 11'h705, 8'h00, 1'b0, 1'b0);
        for (int i = 0; i < NUM_RAND; i++) begin
            ra[i]    = 11'($urandom);
            order[i] = i;
            add_step(OP_WR, ra[i], 8'($urandom), 1'b0, 1'b0);
        end
        for (int i = NUM_RAND - 1; i > 0; i--) begin
            j        = int'($urandom % 32'(i + 1));
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < NUM_RAND; i++)
            add_step(OP_RD, ra[order[i]], 8'h00, 1'b0, 1'b0);
        add_step(OP_WR, 11'h123, 8'hff, 1'b1, 1'b0);
        add_step(OP_RD, 11'h123, 8'h00, 1'b1, 1'b0);
        add_step(OP_RD, 11'h123, 8'h00, 1'b0, 1'b0);
        add_step(OP_BOTH, 11'h2aa, 8'h3c, 1'b0, 1'b1);
        add_step(OP_RD, 11'h2aa, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic wait_for_ack();
        do begin
            @(posedge CLK);
            #1;
        end while (ACK !== 1'b1);
    endtask

    task automatic run_step(input int i);
        step_t s;
        s = steps[i];
        @(posedge CLK);
        #1;
        mute      = s.mute;
        addr.flat = s.addr;
        wdata     = s.data;
        WR        = (s.op != OP_RD);
        RD        = (s.op != OP_WR);
        @(posedge CLK);
        #1;
        WR = 1'b0;
        RD = 1'b0;
        if (s.poke) begin
            repeat (3) @(posedge CLK);
            #1;
            RD = 1'b1;
            repeat (20) @(posedge CLK);
            #1;
            RD = 1'b0;
        end
        wait_for_ack();
        check_value("nack", 32'(nack), 32'(s.exp_nack));
        if (s.op == OP_RD && !s.mute)
            check_value("rdata", 32'(rdata), 32'(s.exp_rdata));
        @(posedge CLK);
        #1;
        check_value("ACK", 32'(ACK), 32'd0);
        check_value("ack_count", 32'(ack_count), 32'(i + 1));
        if (s.poke) begin
            // a queued strobe would still produce a late ACK here
            repeat (45 * BIT_CYCLES) @(posedge CLK);
            #1;
            check_value("ack_count", 32'(ack_count), 32'(i + 1));
        end
    endtask

    initial begin
        void'($urandom(SEED));
        build_table();
        check_value("n_steps", 32'(n_steps), 32'(NUM_STEPS));
        repeat (5) @(posedge CLK);
        #1;
        RESET = 1'b0;
        repeat (8) begin
            @(posedge CLK);
            #1;
            check_value("ACK", 32'(ACK), 32'd0);
            check_value("nack", 32'(nack), 32'd0);
            check_value("SCL", 32'(SCL), 32'd1);
            check_value("SDA", 32'(SDA), 32'd1);
        end
        for (int i = 0; i < NUM_STEPS; i++)
            run_step(i);
        $display("Simulation finished: PASS");
        $finish;
    end

    initial begin
        #(RUN_LIMIT_NS);
        abort_run("watchdog expired, ACK never came for the current request");
    end

endmodule

// File: project.f
source/eeprom_pkg.sv
source/xfer_pkg.sv
source/cmd_decode.sv
source/i2c_xfer_engine.sv
source/xfer_result.sv
source/eeprom_ctrl_top.sv
dv/eeprom_model.sv
dv/tb_eeprom_ctrl.sv

// File: source/cmd_decode.sv
module cmd_decode (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    WR,
    input  logic                    RD,
    input  eeprom_pkg::eeprom_addr_u addr,
    input  logic [7:0]              wdata,
    input  xfer_pkg::xfer_status_t  status,
    output logic                    start,
    output xfer_pkg::xfer_cmd_t     cmd
);

    import eeprom_pkg::*;

    logic busy;
    logic accept;

    // strobes only count while nothing is in flight
    assign accept = !busy && (WR || RD);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            if (busy) begin
                if (status.done)
                    busy <= 1'b0;
            end else if (accept) begin
                busy  <= 1'b1;
                start <= 1'b1;
            end
        end
    end

    // request latch, held until the next accept
    always_ff @(posedge CLK) begin
        if (accept) begin
            cmd.is_read   <= !WR;  // WR wins a tie
            cmd.ctrl_byte <= {DEV_TYPE, addr.blk.block, RW_WRITE};
            cmd.word_addr <= addr.blk.word;
            cmd.wdata     <= wdata;
        end
    end

    // no second start until the engine has reported back
    a_no_start_in_flight: assert property (
        @(posedge CLK) disable iff (RESET)
        start |=> (!start throughout status.done [->1])
    ) else $error("start issued while a transfer was in flight");

endmodule

// File: source/eeprom_ctrl_top.sv
module eeprom_ctrl_top #(
    parameter int SCL_QUARTER = 4
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    WR,
    input  logic                    RD,
    input  eeprom_pkg::eeprom_addr_u addr,
    input  logic [7:0]              wdata,
    output logic [7:0]              rdata,
    output logic                    ACK,
    output logic                    nack,
    output logic                    SCL,
    inout  wire                     SDA
);

    import xfer_pkg::*;

    xfer_cmd_t    cmd;
    xfer_status_t status;
    logic         start;
    logic         sda_drive_low;

    assign SDA = sda_drive_low ? 1'b0 : 1'bz;  // open drain, pull-up is external

    cmd_decode u_cmd_decode (
        .CLK    (CLK),
        .RESET  (RESET),
        .WR     (WR),
        .RD     (RD),
        .addr   (addr),
        .wdata  (wdata),
        .status (status),
        .start  (start),
        .cmd    (cmd)
    );

    i2c_xfer_engine #(
        .SCL_QUARTER (SCL_QUARTER)
    ) u_engine (
        .CLK           (CLK),
        .RESET         (RESET),
        .start         (start),
        .cmd           (cmd),
        .scl           (SCL),
        .sda_drive_low (sda_drive_low),
        .sda_in        (SDA),
        .status        (status)
    );

    xfer_result u_result (
        .CLK    (CLK),
        .RESET  (RESET),
        .status (status),
        .rdata  (rdata),
        .nack   (nack),
        .ack    (ACK)
    );

endmodule

// File: source/eeprom_pkg.sv
package eeprom_pkg;

    // 2 kB array seen as 8 blocks of 256 bytes
    typedef struct packed {
        logic [2:0] block;  // lands in the control byte
        logic [7:0] word;   // sent as the word address byte
    } eeprom_blk_t;

    typedef union packed {
        logic [10:0] flat;
        eeprom_blk_t blk;
    } eeprom_addr_u;

    // control byte layout: type, block, r/w
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

endpackage

// File: source/i2c_xfer_engine.sv
module i2c_xfer_engine #(
    parameter int SCL_QUARTER = 4
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   start,
    input  xfer_pkg::xfer_cmd_t    cmd,
    output logic                   scl,
    output logic                   sda_drive_low,
    input  logic                   sda_in,
    output xfer_pkg::xfer_status_t status
);

    import eeprom_pkg::*;

    localparam int QW = $clog2(SCL_QUARTER);

    typedef enum logic [2:0] {
        IDLE,
        START,
        SEND,
        SACK,
        RSTART,
        RECV,
        MNACK,
        STOP
    } phase_t;

    phase_t        phase;
    logic [QW-1:0] q_cnt;     // clocks within a quarter
    logic [1:0]    qtr;       // quarter within a bit period
    logic [2:0]    bit_cnt;
    logic [1:0]    byte_sel;  // 0 ctrl, 1 word addr, 2 data or read ctrl
    logic [7:0]    shift;
    logic          ack_bad;
    logic          done_q;
    logic          nack_q;
    logic [7:0]    rdata_q;
    logic          q_end;
    logic          bit_end;
    logic          sample;

    assign q_end   = (q_cnt == QW'(SCL_QUARTER - 1));
    assign bit_end = q_end && (qtr == 2'd3);
    // one clock after SCL rose, so SCL is already high at the pin
    assign sample  = (q_cnt == QW'(1)) && (qtr == 2'd2);

    assign status = '{done: done_q, nack: nack_q, rdata: rdata_q};

    always_ff @(posedge CLK) begin
        if (RESET) begin
            q_cnt <= '0;
            qtr   <= 2'd0;
        end else if (phase == IDLE) begin
            q_cnt <= '0;
            qtr   <= 2'd0;
        end else if (q_end) begin
            q_cnt <= '0;
            qtr   <= qtr + 2'd1;
        end else begin
            q_cnt <= q_cnt + QW'(1);
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            phase    <= IDLE;
            bit_cnt  <= 3'd0;
            byte_sel <= 2'd0;
            ack_bad  <= 1'b0;
            done_q   <= 1'b0;
            nack_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (sample && phase == SACK)
                ack_bad <= sda_in;  // released line means nobody answered
            case (phase)
                IDLE: if (start) begin
                    phase  <= START;
                    nack_q <= 1'b0;
                end
                START: if (bit_end) begin
                    phase    <= SEND;
                    bit_cnt  <= 3'd7;
                    byte_sel <= 2'd0;
                end
                SEND: if (bit_end) begin
                    if (bit_cnt == 3'd0)
                        phase <= SACK;
                    bit_cnt <= bit_cnt - 3'd1;  // wraps to 7 for the next byte
                end
                SACK: if (bit_end) begin
                    if (ack_bad) begin
                        phase   <= STOP;
                        nack_q  <= 1'b1;
                        bit_cnt <= 3'd1;
                    end else begin
                        case (byte_sel)
                            2'd0: phase <= SEND;
                            2'd1: phase <= cmd.is_read ? RSTART : SEND;
                            default: begin
                                if (cmd.is_read) begin
                                    phase <= RECV;
                                end else begin
                                    phase   <= STOP;
                                    bit_cnt <= 3'd1;
                                end
                            end
                        endcase
                        byte_sel <= byte_sel + 2'd1;
                    end
                end
                RSTART: if (bit_end)
                    phase <= SEND;
                RECV: if (bit_end) begin
                    if (bit_cnt == 3'd0)
                        phase <= MNACK;
                    bit_cnt <= bit_cnt - 3'd1;
                end
                MNACK: if (bit_end) begin
                    phase   <= STOP;
                    bit_cnt <= 3'd1;
                end
                STOP: if (bit_end) begin
                    // second period is bus free time
                    if (bit_cnt[0]) begin
                        bit_cnt <= 3'd0;
                    end else begin
                        phase  <= IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (phase == START && bit_end)
            shift <= cmd.ctrl_byte;
        else if (phase == SEND && bit_end)
            shift <= {shift[6:0], 1'b0};  // msb first
        else if (phase == SACK && bit_end)
            shift <= (byte_sel == 2'd0) ? cmd.word_addr : cmd.wdata;
        else if (phase == RSTART && bit_end)
            shift <= {cmd.ctrl_byte[7:1], RW_READ};
        else if (phase == RECV && sample)
            shift <= {shift[6:0], sda_in};

        if (phase == MNACK && bit_end)
            rdata_q <= shift;
    end

    // pin levels, updated at the first clock of each quarter
    always_ff @(posedge CLK) begin
        if (RESET) begin
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
        end else if (q_cnt == '0) begin
            case (phase)
                IDLE: begin
                    scl           <= 1'b1;
                    sda_drive_low <= 1'b0;
                end
                START: begin
                    scl <= 1'b1;
                    if (qtr == 2'd2)
                        sda_drive_low <= 1'b1;  // start condition
                end
                SEND: begin
                    scl <= qtr[1];
                    if (qtr == 2'd1)
                        sda_drive_low <= ~shift[7];
                end
                RSTART: begin
                    scl <= qtr[1];
                    if (qtr == 2'd1)
                        sda_drive_low <= 1'b0;
                    else if (qtr == 2'd3)
                        sda_drive_low <= 1'b1;
                end
                STOP: begin
                    scl <= qtr[1] || !bit_cnt[0];
                    if (bit_cnt[0] && qtr == 2'd1)
                        sda_drive_low <= 1'b1;
                    else if (bit_cnt[0] && qtr == 2'd3)
                        sda_drive_low <= 1'b0;  // stop condition
                end
                default: begin
                    // slave ack, read data and master nack all leave SDA free
                    scl <= qtr[1];
                    if (qtr == 2'd1)
                        sda_drive_low <= 1'b0;
                end
            endcase
        end
    end

    a_sda_scl_low: assert property (
        @(posedge CLK) disable iff (RESET)
        ($changed(sda_drive_low) && !(phase inside {START, RSTART, STOP})) |-> !scl
    ) else $error("SDA moved while SCL was high outside start/stop");

endmodule

// File: source/xfer_pkg.sv
package xfer_pkg;

    // one request as handed to the bus engine
    typedef struct packed {
        logic       is_read;
        logic [7:0] ctrl_byte;  // type, block and write bit already in place
        logic [7:0] word_addr;
        logic [7:0] wdata;
    } xfer_cmd_t;

    // engine result, valid while done is high
    typedef struct packed {
        logic       done;   // single cycle
        logic       nack;   // some byte went unacknowledged
        logic [7:0] rdata;  // last byte read from the device
    } xfer_status_t;

endpackage

// File: source/xfer_result.sv
module xfer_result (
    input  logic                   CLK,
    input  logic                   RESET,
    input  xfer_pkg::xfer_status_t status,
    output logic [7:0]             rdata,
    output logic                   nack,
    output logic                   ack
);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            ack  <= 1'b0;
            nack <= 1'b0;
        end else begin
            ack <= status.done;  // one cycle after done
            if (status.done)
                nack <= status.nack;
        end
    end

    // engine keeps its read byte across writes
    always_ff @(posedge CLK) begin
        if (status.done)
            rdata <= status.rdata;
    end

    a_ack_single: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |=> !ack
    ) else $error("ACK high for two cycles in a row");

endmodule
